/* hdc_pkg.sv */
package hdc_pkg;

    // hypervector width, reduced for simulation
    localparam int hv_width = 64;

    // item memory geometry
    localparam int mem_depth = 1024;
    localparam int addr_width = 10;

    // requesters on the memory port: 0 host, 1 core 0, 2 core 1
    localparam int num_req = 3;
    localparam int req_sel_width = $clog2(num_req);

    typedef logic [hv_width-1:0] hv_t;

    // addressed form, bit 15 set
    typedef struct packed {
        logic                  has_addr;
        logic                  load;
        logic                  rshift;
        logic                  lshift;
        logic                  xor_op;
        logic                  spare;
        logic [addr_width-1:0] addr;
    } inst_mem_t;

    // register form, bit 15 clear
    typedef struct packed {
        logic       has_addr;
        logic       rshift;
        logic       lshift;
        logic       xor_op;
        logic       store;
        logic       last_store;
        logic       move;
        logic [8:0] spare;
    } inst_reg_t;

    // has_addr sits at bit 15 in both views
    typedef union packed {
        inst_mem_t mem_form;
        inst_reg_t reg_form;
    } hdc_inst_t;

    typedef struct packed {
        logic                  we;
        logic [addr_width-1:0] addr;
        hv_t                   wdata;
    } mem_req_t;

    typedef struct packed {
        hv_t  data;
        logic last;
    } hdc_result_t;

    // core sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait
    } core_state_t;

endpackage

/* item_memory.sv */
`timescale 1ns/1ps

module item_memory
    import hdc_pkg::*;
(
    input  logic     clk,
    input  logic     en,
    input  mem_req_t req,
    output hv_t      rd_data
);

    // random item vectors, loaded by the host
    hv_t mem [mem_depth];

    // single port, write or read per enabled cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                // registered read, one cycle latency
                rd_data <= mem[req.addr];
            end
        end
    end

    // held between reads so a stalled core still sees its vector

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import hdc_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [num_req-1:0]             req_valid,
    input  mem_req_t [num_req-1:0]         req,
    output logic [num_req-1:0]             grant,
    output logic                           mem_en,
    output mem_req_t                       mem_req_out
);

    // index of the last requester granted
    logic [req_sel_width-1:0] ptr;
    // index of the requester granted this cycle
    logic [req_sel_width-1:0] sel;

    // search starts one past ptr and wraps
    always_comb begin
        int unsigned idx;
        logic        found;
        found = 1'b0;
        sel   = ptr;
        grant = '0;
        for (int i = 1; i <= num_req; i++) begin
            idx = (int'(ptr) + i) % num_req;
            if (!found && req_valid[idx]) begin
                found      = 1'b1;
                sel        = idx[req_sel_width-1:0];
                grant[idx] = 1'b1;
            end
        end
    end

    // any grant drives the memory this cycle
    assign mem_en = |grant;
    assign mem_req_out = req[sel];

    // pointer moves only on a grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // host gets first pick out of reset
            ptr <= req_sel_width'(num_req - 1);
        end else if (mem_en) begin
            ptr <= sel;
        end
    end

    // at most one grant, and never to an idle requester
    a_grant_legal : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && ((grant & ~req_valid) == '0)
    );

    // a requester left waiting is not passed over twice in a row
    a_no_starve : assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_en && (req_valid & ~grant) != '0) |=>
            (sel != $past(sel)) || !mem_en
    );

endmodule

/* hdc_core.sv */
`timescale 1ns/1ps

module hdc_core
    import hdc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  hdc_inst_t   inst,
    output logic        inst_ready,
    output logic        mem_valid,
    output mem_req_t    mem_req,
    input  logic        mem_grant,
    input  hv_t         rd_data,
    output logic        res_valid,
    output hdc_result_t res,
    input  logic        res_ready
);

    // rotate right by one bit
    function automatic hv_t rot_r(input hv_t v);
        return {v[0], v[hv_width-1:1]};
    endfunction

    // rotate left by one bit
    function automatic hv_t rot_l(input hv_t v);
        return {v[hv_width-2:0], v[hv_width-1]};
    endfunction

    core_state_t state;
    // working register
    hv_t acc;
    // copy register, source of register xor
    hv_t copy_hv;
    // addressed instruction held across the fetch
    hdc_inst_t pend_inst;

    logic inst_accept;
    logic res_load;
    logic res_done;

    // accept only when idle and nothing left to hand back
    assign inst_ready = (state == st_idle) && !res_valid;
    assign inst_accept = inst_valid && inst_ready;

    // store wins only if no rotate or xor bit is set
    assign res_load = inst_accept && !inst.reg_form.has_addr
                      && !inst.reg_form.rshift && !inst.reg_form.lshift
                      && !inst.reg_form.xor_op
                      && (inst.reg_form.store || inst.reg_form.last_store);
    assign res_done = res_valid && res_ready;

    // read request toward the arbiter
    assign mem_valid = (state == st_fetch);
    assign mem_req.we = 1'b0;
    assign mem_req.addr = pend_inst.mem_form.addr;
    assign mem_req.wdata = '0;

    // control and architectural registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            res_valid <= 1'b0;
            acc       <= '0;
            copy_hv   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (res_done) begin
                        res_valid <= 1'b0;
                        // program finished, start the next one from zero
                        if (res.last) begin
                            acc     <= '0;
                            copy_hv <= '0;
                        end
                    end else if (inst_accept) begin
                        if (inst.mem_form.has_addr) begin
                            state <= st_fetch;
                        end else if (inst.reg_form.rshift) begin
                            acc <= rot_r(acc);
                        end else if (inst.reg_form.lshift) begin
                            acc <= rot_l(acc);
                        end else if (inst.reg_form.xor_op) begin
                            acc <= copy_hv ^ acc;
                        end else if (inst.reg_form.store || inst.reg_form.last_store) begin
                            // result payload latched in the data block
                            res_valid <= 1'b1;
                        end else if (inst.reg_form.move) begin
                            copy_hv <= acc;
                        end
                        // no op bit set, nothing to do
                    end
                end
                st_fetch: begin
                    // read issued this cycle, data next
                    if (mem_grant) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // rd_data holds our vector now
                    if (pend_inst.mem_form.load) begin
                        acc <= rd_data;
                    end else if (pend_inst.mem_form.rshift) begin
                        acc <= rot_r(rd_data);
                    end else if (pend_inst.mem_form.lshift) begin
                        acc <= rot_l(rd_data);
                    end else if (pend_inst.mem_form.xor_op) begin
                        acc <= rd_data ^ acc;
                    end
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (inst_accept && inst.mem_form.has_addr) begin
            pend_inst <= inst;
        end
        if (res_load) begin
            res.data <= acc;
            // plain store has priority over last store
            res.last <= !inst.reg_form.store;
        end
    end

    // result held steady under back-pressure
    a_res_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res))
    );

    // a fetch only starts from an accepted addressed instruction
    a_fetch_start : assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(mem_valid) |-> $past(inst_accept && inst.mem_form.has_addr)
    );

endmodule

/* hdc_top.sv */
`timescale 1ns/1ps

module hdc_top
    import hdc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst0_valid,
    input  hdc_inst_t   inst0,
    output logic        inst0_ready,
    input  logic        inst1_valid,
    input  hdc_inst_t   inst1,
    output logic        inst1_ready,
    input  logic        load_valid,
    input  mem_req_t    load_req,
    output logic        load_ready,
    output logic        res0_valid,
    output hdc_result_t res0,
    input  logic        res0_ready,
    output logic        res1_valid,
    output hdc_result_t res1,
    input  logic        res1_ready
);

    // arbiter side, index 0 host, 1 core 0, 2 core 1
    logic [num_req-1:0]     req_valid;
    mem_req_t [num_req-1:0] req;
    logic [num_req-1:0]     grant;

    // memory port
    logic     mem_en;
    mem_req_t mem_req;
    // shared read data, every core sees it
    hv_t      rd_data;

    // host writes complete on grant
    assign load_ready = grant[0];
    assign req_valid[0] = load_valid;
    assign req[0] = load_req;

    hdc_core core0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst0_valid),
        .inst       (inst0),
        .inst_ready (inst0_ready),
        .mem_valid  (req_valid[1]),
        .mem_req    (req[1]),
        .mem_grant  (grant[1]),
        .rd_data    (rd_data),
        .res_valid  (res0_valid),
        .res        (res0),
        .res_ready  (res0_ready)
    );

    hdc_core core1 (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst1_valid),
        .inst       (inst1),
        .inst_ready (inst1_ready),
        .mem_valid  (req_valid[2]),
        .mem_req    (req[2]),
        .mem_grant  (grant[2]),
        .rd_data    (rd_data),
        .res_valid  (res1_valid),
        .res        (res1),
        .res_ready  (res1_ready)
    );

    mem_arbiter arb0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .grant       (grant),
        .mem_en      (mem_en),
        .mem_req_out (mem_req)
    );

    item_memory imem0 (
        .clk     (clk),
        .en      (mem_en),
        .req     (mem_req),
        .rd_data (rd_data)
    );

endmodule

/* tb_hdc_top.sv */
`timescale 1ns/1ps

module tb_hdc_top
    import hdc_pkg::*;
;

    localparam int max_rows = 64;
    localparam int n_base = 16;
    localparam int n_extra = 8;
    localparam int ow_addr = 5;

    logic        clk;
    logic        arst_n;
    logic        inst0_valid;
    hdc_inst_t   inst0;
    logic        inst0_ready;
    logic        inst1_valid;
    hdc_inst_t   inst1;
    logic        inst1_ready;
    logic        load_valid;
    mem_req_t    load_req;
    logic        load_ready;
    logic        res0_valid;
    hdc_result_t res0;
    logic        res0_ready;
    logic        res1_valid;
    hdc_result_t res1;
    logic        res1_ready;

    // stimulus table
    int          row_core [max_rows];
    logic [15:0] row_inst [max_rows];
    bit          row_has [max_rows];
    hv_t         row_data [max_rows];
    bit          row_last [max_rows];
    int          n_rows;
    int          seg_b;

    // vectors kept by the testbench
    hv_t         vecs [n_base + n_extra];
    hv_t         new_vec;
    hdc_result_t exp_q0 [$];
    hdc_result_t exp_q1 [$];

    int          errors;
    int          cycles;
    int          limit;
    bit          held0;
    bit          held1;
    hdc_result_t prev0;
    hdc_result_t prev1;

    hdc_top dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] mi(bit ld, bit r, bit l, bit x, int addr);
        return {1'b1, ld, r, l, x, 1'b0, addr[addr_width-1:0]};
    endfunction

    function automatic logic [15:0] ri(bit r, bit l, bit x, bit st, bit ls, bit mv);
        return {1'b0, r, l, x, st, ls, mv, 9'b0};
    endfunction

    task automatic add_row(int core, logic [15:0] word);
        row_core[n_rows] = core;
        row_inst[n_rows] = word;
        n_rows++;
    endtask

    task automatic check(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // expected results from the decode rules, walking rows in order
    task automatic build_expected();
        hv_t       acc [2];
        hv_t       cpy [2];
        hv_t       ref_mem [64];
        hv_t       fetched;
        hdc_inst_t w;
        int        c;
        for (int i = 0; i < n_base + n_extra; i++) begin
            ref_mem[i] = vecs[i];
        end
        acc = '{default: '0};
        cpy = '{default: '0};
        for (int i = 0; i < n_rows; i++) begin
            if (i == seg_b) begin
                ref_mem[ow_addr] = new_vec;
            end
            w = row_inst[i];
            c = row_core[i];
            row_has[i] = 1'b0;
            if (w.mem_form.has_addr) begin
                fetched = ref_mem[w.mem_form.addr];
                if (w.mem_form.load) begin
                    acc[c] = fetched;
                end else if (w.mem_form.rshift) begin
                    acc[c] = (fetched >> 1) | (fetched << (hv_width - 1));
                end else if (w.mem_form.lshift) begin
                    acc[c] = (fetched << 1) | (fetched >> (hv_width - 1));
                end else if (w.mem_form.xor_op) begin
                    acc[c] = fetched ^ acc[c];
                end
            end else if (w.reg_form.rshift) begin
                acc[c] = (acc[c] >> 1) | (acc[c] << (hv_width - 1));
            end else if (w.reg_form.lshift) begin
                acc[c] = (acc[c] << 1) | (acc[c] >> (hv_width - 1));
            end else if (w.reg_form.xor_op) begin
                acc[c] = cpy[c] ^ acc[c];
            end else if (w.reg_form.store) begin
                row_has[i] = 1'b1;
                row_data[i] = acc[c];
                row_last[i] = 1'b0;
            end else if (w.reg_form.last_store) begin
                row_has[i] = 1'b1;
                row_data[i] = acc[c];
                row_last[i] = 1'b1;
                // end of program wipes both registers
                acc[c] = '0;
                cpy[c] = '0;
            end else if (w.reg_form.move) begin
                cpy[c] = acc[c];
            end
        end
    endtask

    // caller sits on a falling edge
    task automatic send_inst(int core, logic [15:0] word);
        if (core == 0) begin
            inst0_valid = 1'b1;
            inst0 = word;
        end else begin
            inst1_valid = 1'b1;
            inst1 = word;
        end
        #1;
        while (!(core == 0 ? inst0_ready : inst1_ready)) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        if (core == 0) begin
            inst0_valid = 1'b0;
        end else begin
            inst1_valid = 1'b0;
        end
    endtask

    task automatic host_write(int addr, hv_t data);
        load_valid = 1'b1;
        load_req.we = 1'b1;
        load_req.addr = addr[addr_width-1:0];
        load_req.wdata = data;
        #1;
        while (!load_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic feed(int core, int first, int last);
        for (int i = first; i < last; i++) begin
            if (row_core[i] == core) begin
                send_inst(core, row_inst[i]);
            end
        end
    endtask

    // random back-pressure on both result ports
    always @(negedge clk) begin
        res0_ready = ($urandom % 3) != 0;
        res1_ready = ($urandom % 3) != 0;
    end

    // result monitor, in order per core
    always @(posedge clk) begin
        if (arst_n) begin
            // a stalled result keeps valid and payload
            if (held0) begin
                check("res0_valid held", res0_valid, 1'b1);
                check("res0 held", res0, prev0);
            end
            if (res0_valid && res0_ready) begin
                if (exp_q0.size() == 0) begin
                    $display("Core 0 produced a result that was not expected at %0t ns", $time);
                    errors++;
                end else begin
                    check("res0.data", res0.data, exp_q0[0].data);
                    check("res0.last", res0.last, exp_q0[0].last);
                    void'(exp_q0.pop_front());
                end
            end
            held0 = res0_valid && !res0_ready;
            prev0 = res0;
            if (held1) begin
                check("res1_valid held", res1_valid, 1'b1);
                check("res1 held", res1, prev1);
            end
            if (res1_valid && res1_ready) begin
                if (exp_q1.size() == 0) begin
                    $display("Core 1 produced a result that was not expected at %0t ns", $time);
                    errors++;
                end else begin
                    check("res1.data", res1.data, exp_q1[0].data);
                    check("res1.last", res1.last, exp_q1[0].last);
                    void'(exp_q1.pop_front());
                end
            end
            held1 = res1_valid && !res1_ready;
            prev1 = res1;
        end
    end

    // run limit from table length and load count
    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, the run hung", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h5689));
        clk = 1'b0;
        arst_n = 1'b0;
        inst0_valid = 1'b0;
        inst0 = '0;
        inst1_valid = 1'b0;
        inst1 = '0;
        load_valid = 1'b0;
        load_req = '0;
        res0_ready = 1'b0;
        res1_ready = 1'b0;
        errors = 0;
        cycles = 0;
        held0 = 1'b0;
        held1 = 1'b0;
        n_rows = 0;
        for (int i = 0; i < n_base + n_extra; i++) begin
            vecs[i] = {$urandom, $urandom};
        end
        new_vec = {$urandom, $urandom};

        // core 0: load and store, rotations
        add_row(0, mi(1, 0, 0, 0, 0));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, mi(1, 0, 0, 0, 1));
        add_row(0, ri(1, 0, 0, 0, 0, 0));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, ri(0, 1, 0, 0, 0, 0));
        add_row(0, ri(0, 1, 0, 0, 0, 0));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, mi(0, 1, 0, 0, 2));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, mi(0, 0, 1, 0, 3));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        // core 0: xor paths and priority
        add_row(0, mi(1, 0, 0, 0, 4));
        add_row(0, ri(0, 0, 0, 0, 0, 1));
        add_row(0, mi(0, 0, 0, 1, 6));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, ri(0, 0, 1, 0, 0, 0));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, ri(1, 0, 0, 1, 0, 0));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, mi(1, 1, 0, 1, 7));
        add_row(0, 16'h0000);
        add_row(0, ri(0, 0, 0, 0, 1, 0));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        // core 1: fetches that collide with core 0 and the host
        add_row(1, mi(1, 0, 0, 0, 8));
        add_row(1, ri(0, 0, 0, 1, 0, 0));
        add_row(1, mi(0, 0, 1, 0, 9));
        add_row(1, ri(0, 0, 0, 0, 0, 1));
        add_row(1, mi(0, 1, 0, 0, 10));
        add_row(1, ri(0, 0, 1, 1, 0, 0));
        add_row(1, ri(0, 0, 0, 1, 1, 0));
        add_row(1, mi(0, 0, 0, 1, 11));
        add_row(1, ri(0, 1, 1, 0, 0, 1));
        add_row(1, ri(0, 0, 0, 0, 1, 0));
        add_row(1, ri(0, 0, 0, 1, 0, 0));
        add_row(1, mi(1, 0, 0, 0, 12));
        add_row(1, ri(0, 0, 0, 0, 1, 0));
        // after the overwrite, and the vectors loaded during the run
        seg_b = n_rows;
        add_row(0, mi(1, 0, 0, 0, ow_addr));
        add_row(0, ri(0, 0, 0, 1, 0, 0));
        add_row(0, mi(1, 0, 0, 0, 16));
        add_row(0, ri(0, 0, 0, 0, 1, 0));
        add_row(1, mi(1, 0, 0, 0, 20));
        add_row(1, mi(0, 0, 0, 1, 23));
        add_row(1, ri(0, 0, 0, 0, 1, 0));

        build_expected();
        for (int i = 0; i < n_rows; i++) begin
            if (row_has[i]) begin
                if (row_core[i] == 0) begin
                    exp_q0.push_back(hdc_result_t'{data: row_data[i], last: row_last[i]});
                end else begin
                    exp_q1.push_back(hdc_result_t'{data: row_data[i], last: row_last[i]});
                end
            end
        end
        limit = 40 * n_rows + 40 * (n_base + n_extra + 1) + 16;

        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < n_base; i++) begin
            host_write(i, vecs[i]);
        end
        // both streams run while the host keeps loading
        fork
            feed(0, 0, seg_b);
            feed(1, 0, seg_b);
            begin
                for (int i = n_base; i < n_base + n_extra; i++) begin
                    host_write(i, vecs[i]);
                end
            end
        join
        host_write(ow_addr, new_vec);
        fork
            feed(0, seg_b, n_rows);
            feed(1, seg_b, n_rows);
        join
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* hdc_top.f */
hdc_pkg.sv
item_memory.sv
mem_arbiter.sv
hdc_core.sv
hdc_top.sv
tb_hdc_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_hdc_top
RTL_TOP   ?= hdc_top
FILELIST  ?= hdc_top.f
PASS_MSG  := Verification passed

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
